// File: Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert
TOP      := datapath_core_tb
FILELIST := vlog.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: channel/channel_filter.sv
`timescale 1ns/1ns
`default_nettype none

module channel_filter (
    input  wire                           clk,
    input  wire                           rst_i,
    input  wire                           valid_i,
    input  wire dsp_types_pkg::bit_word_t bits_i,
    input  wire dsp_cfg_pkg::dsp_cfg_t    cfg_i,
    output logic                          valid_o,
    output dsp_types_pkg::est_code_word_t est_codes_o
);

    localparam int hist_len = dsp_cfg_pkg::chan_taps - 1;
    localparam int ext_len  = dsp_types_pkg::lanes + hist_len;
    localparam int acc_w    = dsp_types_pkg::est_code_w + 1;

    typedef logic signed [acc_w-1:0] acc_t;

    logic [hist_len-1:0]            hist_q;
    logic [ext_len-1:0]             ext;
    dsp_types_pkg::est_code_word_t  est_d;
    dsp_types_pkg::est_code_word_t  est_q;
    logic                           valid_q;

    assign ext = {bits_i, hist_q};

    // Bit 1 adds the tap, bit 0 subtracts it
    always_comb begin
        acc_t              acc;
        dsp_cfg_pkg::tap_t h;
        for (int i = 0; i < dsp_types_pkg::lanes; i++) begin
            acc = '0;
            for (int j = 0; j < dsp_cfg_pkg::chan_taps; j++) begin
                h = cfg_i.taps[j];
                if (ext[hist_len + i - j]) begin
                    acc = acc + acc_t'(h);
                end else begin
                    acc = acc - acc_t'(h);
                end
            end
            acc = acc >>> cfg_i.chan_shift;
            est_d.lane[i] = dsp_types_pkg::est_code_t'(acc);
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_q <= 1'b0;
            hist_q  <= '0;
        end else begin
            valid_q <= valid_i;
            if (valid_i) begin
                hist_q <= bits_i[dsp_types_pkg::lanes-1:dsp_types_pkg::lanes-hist_len];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (valid_i) begin
            est_q <= est_d;
        end
    end

    assign valid_o     = valid_q;
    assign est_codes_o = est_q;

endmodule

`default_nettype wire

// File: common/dsp_cfg_pkg.sv
`default_nettype none

package dsp_cfg_pkg;

    parameter int ffe_taps  = 3;
    parameter int chan_taps = 3;

    parameter int weight_w = 8;
    parameter int thresh_w = 16;
    parameter int tap_w    = 8;
    parameter int shift_w  = 4;

    typedef logic signed [weight_w-1:0] weight_t;
    typedef logic signed [thresh_w-1:0] thresh_t;
    typedef logic signed [tap_w-1:0]    tap_t;

    // Arithmetic right shift amount
    typedef logic [shift_w-1:0] shift_t;

    // Static receiver configuration with index 0 as the main tap
    typedef struct packed {
        weight_t [ffe_taps-1:0]  weights;
        shift_t                  ffe_shift;
        thresh_t                 thresh;
        tap_t    [chan_taps-1:0] taps;
        shift_t                  chan_shift;
    } dsp_cfg_t;

endpackage

`default_nettype wire

// File: common/dsp_types_pkg.sv
`default_nettype none

package dsp_types_pkg;

    // Lanes per word with lane 0 as the oldest sample
    parameter int lanes = 4;

    parameter int code_w     = 8;
    parameter int est_bit_w  = 16;
    parameter int est_code_w = 10;
    parameter int err_w      = 11;

    // ADC code
    typedef logic signed [code_w-1:0] code_t;

    // FFE output before slicing
    typedef logic signed [est_bit_w-1:0] est_bit_t;

    // Channel filter output
    typedef logic signed [est_code_w-1:0] est_code_t;

    // Expected code minus received code
    typedef logic signed [err_w-1:0] err_t;

    typedef struct packed {
        code_t [lanes-1:0] lane;
    } code_word_t;

    typedef struct packed {
        est_bit_t [lanes-1:0] lane;
    } est_bit_word_t;

    typedef struct packed {
        est_code_t [lanes-1:0] lane;
    } est_code_word_t;

    typedef struct packed {
        err_t [lanes-1:0] lane;
    } err_word_t;

    // One bit per lane
    typedef logic [lanes-1:0] bit_word_t;
    typedef logic [lanes-1:0] flag_word_t;

endpackage

`default_nettype wire

// File: detector/error_detector.sv
`timescale 1ns/1ns
`default_nettype none

module error_detector (
    input  wire                                clk,
    input  wire                                rst_i,
    input  wire                                valid_i,
    input  wire dsp_types_pkg::est_code_word_t est_codes_i,
    input  wire dsp_types_pkg::code_word_t     codes_i,
    input  wire dsp_types_pkg::bit_word_t      bits_i,
    input  wire dsp_cfg_pkg::dsp_cfg_t         cfg_i,
    output logic                               valid_o,
    output dsp_types_pkg::err_word_t           errors_o,
    output dsp_types_pkg::flag_word_t          flags_o
);

    // Room for the error minus twice the main tap, and its magnitude
    localparam int diff_w = dsp_types_pkg::err_w + 2;

    typedef logic signed [diff_w-1:0] diff_t;

    dsp_types_pkg::err_word_t  err_d;
    dsp_types_pkg::err_word_t  err_q;
    dsp_types_pkg::err_word_t  err_q2;
    dsp_types_pkg::bit_word_t  bits_q;
    dsp_types_pkg::flag_word_t flag_d;
    dsp_types_pkg::flag_word_t flag_q;
    logic                      valid_q;
    logic                      valid_q2;

    always_comb begin
        for (int i = 0; i < dsp_types_pkg::lanes; i++) begin
            err_d.lane[i] = dsp_types_pkg::err_t'(est_codes_i.lane[i])
                          - dsp_types_pkg::err_t'(codes_i.lane[i]);
        end
    end

    // Flipping bit k moves the expected code by twice the main tap
    always_comb begin
        diff_t             step_pos;
        diff_t             step_neg;
        diff_t             e;
        diff_t             e_flip;
        diff_t             mag;
        diff_t             mag_flip;
        dsp_cfg_pkg::tap_t h0;
        h0       = cfg_i.taps[0];
        step_pos = (diff_t'(h0) <<< 1) >>> cfg_i.chan_shift;
        step_neg = (-(diff_t'(h0) <<< 1)) >>> cfg_i.chan_shift;
        for (int i = 0; i < dsp_types_pkg::lanes; i++) begin
            e        = diff_t'(err_q.lane[i]);
            e_flip   = bits_q[i] ? e - step_pos : e - step_neg;
            mag      = (e < 0) ? -e : e;
            mag_flip = (e_flip < 0) ? -e_flip : e_flip;
            flag_d[i] = (mag_flip < mag);
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_q  <= 1'b0;
            valid_q2 <= 1'b0;
        end else begin
            valid_q  <= valid_i;
            valid_q2 <= valid_q;
        end
    end

    always_ff @(posedge clk) begin
        if (valid_i) begin
            err_q  <= err_d;
            bits_q <= bits_i;
        end
        if (valid_q) begin
            err_q2 <= err_q;
            flag_q <= flag_d;
        end
    end

    assign valid_o  = valid_q2;
    assign errors_o = err_q2;
    assign flags_o  = flag_q;

endmodule

`default_nettype wire

// File: dv/datapath_core_assertions.sv
`timescale 1ns/1ns
`default_nettype none

module datapath_core_assertions #(
    parameter int out_stages = 0
) (
    input wire clk,
    input wire rst_i,
    input wire in_valid_i,
    input wire out_valid_i
);

    localparam int latency = 4 + out_stages;

    // Quiet while in reset and on the cycle after
    reset_quiet_a: assert property (
        @(posedge clk) rst_i |=> !out_valid_i
    ) else $error("output strobe during reset");

    release_quiet_a: assert property (
        @(posedge clk) $fell(rst_i) |=> !out_valid_i
    ) else $error("output strobe in the cycle after reset");

    latency_a: assert property (
        @(posedge clk) disable iff (rst_i)
        in_valid_i |-> ##latency out_valid_i
    ) else $error("input strobe not followed by an output strobe at the fixed latency");

    // Every output strobe traces back to an input strobe
    no_orphan_a: assert property (
        @(posedge clk) disable iff (rst_i)
        out_valid_i |-> $past(in_valid_i, latency)
    ) else $error("output strobe without a matching input strobe");

endmodule

`default_nettype wire

// File: dv/datapath_core_tb.sv
`timescale 1ns/1ns
`default_nettype none

module datapath_core_tb;

    localparam int out_stages      = 1;
    localparam int reset_cycles    = 10;
    localparam int words_per_phase = 150;
    localparam int max_gap         = 3;
    localparam int drain_cycles    = 10;
    // Longest case with every gap at its maximum
    localparam int stim_cycles     = reset_cycles + 5 * drain_cycles
                                   + words_per_phase * (max_gap + 3);
    localparam int timeout_cycles  = 2 * stim_cycles + 100;

    typedef struct packed {
        dsp_types_pkg::est_bit_word_t  est_bits;
        dsp_types_pkg::bit_word_t      bits;
        dsp_types_pkg::est_code_word_t est_codes;
        dsp_types_pkg::err_word_t      errors;
        dsp_types_pkg::flag_word_t     flags;
    } expect_t;

    logic                          clk;
    logic                          rst_i;
    dsp_cfg_pkg::dsp_cfg_t         cfg_i;
    logic                          valid_i;
    dsp_types_pkg::code_word_t     codes_i;
    logic                          valid_o;
    dsp_types_pkg::est_bit_word_t  est_bits_o;
    dsp_types_pkg::bit_word_t      bits_o;
    dsp_types_pkg::est_code_word_t est_codes_o;
    dsp_types_pkg::err_word_t      errors_o;
    dsp_types_pkg::flag_word_t     flags_o;

    dsp_cfg_pkg::dsp_cfg_t cur_cfg;
    // Stream history with the older sample first
    // A zero bit counts as -1
    int                    model_codes [2] = '{0, 0};
    int                    model_signs [2] = '{-1, -1};
    expect_t               exp_q [$];
    int                    cycle_count = 0;
    int                    flag_ones   = 0;
    int                    flag_zeros  = 0;

    datapath_core #(.out_stages(out_stages)) dut0 (
        .clk        (clk),
        .rst_i      (rst_i),
        .cfg_i      (cfg_i),
        .valid_i    (valid_i),
        .codes_i    (codes_i),
        .valid_o    (valid_o),
        .est_bits_o (est_bits_o),
        .bits_o     (bits_o),
        .est_codes_o(est_codes_o),
        .errors_o   (errors_o),
        .flags_o    (flags_o)
    );

    bind datapath_core datapath_core_assertions #(.out_stages(out_stages)) assertions0 (
        .clk        (clk),
        .rst_i      (rst_i),
        .in_valid_i (valid_i),
        .out_valid_i(valid_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    function automatic int magnitude(input int v);
        return (v < 0) ? -v : v;
    endfunction

    function automatic dsp_cfg_pkg::dsp_cfg_t random_cfg();
        dsp_cfg_pkg::dsp_cfg_t cfg;
        for (int j = 0; j < dsp_cfg_pkg::ffe_taps; j++) begin
            cfg.weights[j] = dsp_cfg_pkg::weight_t'(int'($urandom_range(95, 0)) - 48);
        end
        cfg.ffe_shift = dsp_cfg_pkg::shift_t'($urandom_range(4, 1));
        cfg.thresh    = dsp_cfg_pkg::thresh_t'(int'($urandom_range(400, 0)) - 200);
        for (int j = 0; j < dsp_cfg_pkg::chan_taps; j++) begin
            cfg.taps[j] = dsp_cfg_pkg::tap_t'(int'($urandom_range(127, 0)) - 64);
        end
        cfg.chan_shift = dsp_cfg_pkg::shift_t'($urandom_range(3, 1));
        return cfg;
    endfunction

    // Pass-through FFE with the threshold off the channel midpoint
    function automatic dsp_cfg_pkg::dsp_cfg_t flag_cfg();
        dsp_cfg_pkg::dsp_cfg_t cfg;
        cfg.weights    = '{8'sd0, 8'sd0, 8'sd1};
        cfg.ffe_shift  = '0;
        cfg.thresh     = 16'sd20;
        cfg.taps       = '{-8'sd8, 8'sd12, 8'sd100};
        cfg.chan_shift = 4'd1;
        return cfg;
    endfunction

    function automatic dsp_types_pkg::code_word_t random_word(input int span);
        dsp_types_pkg::code_word_t word;
        for (int i = 0; i < dsp_types_pkg::lanes; i++) begin
            word.lane[i] = dsp_types_pkg::code_t'(int'($urandom_range(2 * span, 0)) - span);
        end
        return word;
    endfunction

    task automatic predict_word(input dsp_types_pkg::code_word_t word);
        expect_t e;
        int      c [6];
        int      s [6];
        int      sum;
        int      err;
        int      step;
        c[0] = model_codes[0];
        c[1] = model_codes[1];
        s[0] = model_signs[0];
        s[1] = model_signs[1];
        for (int i = 0; i < dsp_types_pkg::lanes; i++) begin
            c[2+i] = int'(word.lane[i]);
        end
        for (int i = 0; i < dsp_types_pkg::lanes; i++) begin
            sum = 0;
            for (int j = 0; j < dsp_cfg_pkg::ffe_taps; j++) begin
                sum = sum + int'(cur_cfg.weights[j]) * c[2+i-j];
            end
            e.est_bits.lane[i] = dsp_types_pkg::est_bit_t'(sum >>> cur_cfg.ffe_shift);
            s[2+i] = (int'(e.est_bits.lane[i]) >= int'(cur_cfg.thresh)) ? 1 : -1;
            e.bits[i] = (s[2+i] > 0);
        end
        for (int i = 0; i < dsp_types_pkg::lanes; i++) begin
            sum = 0;
            for (int j = 0; j < dsp_cfg_pkg::chan_taps; j++) begin
                sum = sum + int'(cur_cfg.taps[j]) * s[2+i-j];
            end
            sum = sum >>> cur_cfg.chan_shift;
            e.est_codes.lane[i] = dsp_types_pkg::est_code_t'(sum);
            err = sum - c[2+i];
            e.errors.lane[i] = dsp_types_pkg::err_t'(err);
            step = (2 * s[2+i] * int'(cur_cfg.taps[0])) >>> cur_cfg.chan_shift;
            e.flags[i] = (magnitude(err - step) < magnitude(err));
        end
        model_codes = '{c[4], c[5]};
        model_signs = '{s[4], s[5]};
        exp_q.push_back(e);
    endtask

    task automatic send_word(input dsp_types_pkg::code_word_t word);
        @(posedge clk);
        valid_i <= 1'b1;
        codes_i <= word;
        predict_word(word);
    endtask

    // Codes during a gap are noise and must not enter the history
    task automatic idle_cycle();
        @(posedge clk);
        valid_i <= 1'b0;
        codes_i <= random_word(128);
    endtask

    task automatic load_cfg(input dsp_cfg_pkg::dsp_cfg_t cfg);
        @(posedge clk);
        cfg_i   <= cfg;
        cur_cfg = cfg;
    endtask

    task automatic drain();
        idle_cycle();
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
    endtask

    task automatic check_field(input string name, input logic [63:0] got,
                               input logic [63:0] want);
        assert (got == want) else begin
            fail_run($sformatf("mismatch at %0t ns: %s is %h, expected %h",
                               $time, name, got, want));
        end
    endtask

    always @(negedge clk) begin
        expect_t e;
        if (valid_o === 1'b1) begin
            if (exp_q.size() == 0) begin
                fail_run("output strobe arrived with no input word in flight");
            end else begin
                e = exp_q.pop_front();
                check_field("est_bits_o", 64'(est_bits_o), 64'(e.est_bits));
                check_field("bits_o", 64'(bits_o), 64'(e.bits));
                check_field("est_codes_o", 64'(est_codes_o), 64'(e.est_codes));
                check_field("errors_o", 64'(errors_o), 64'(e.errors));
                check_field("flags_o", 64'(flags_o), 64'(e.flags));
                flag_ones  = flag_ones + $countones(flags_o);
                flag_zeros = flag_zeros + dsp_types_pkg::lanes - $countones(flags_o);
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= timeout_cycles) begin
            fail_run($sformatf("timeout after %0d cycles", cycle_count));
        end
    end

    initial begin
        int gap;
        void'($urandom(50869));
        rst_i   <= 1'b1;
        valid_i <= 1'b0;
        codes_i <= '0;
        cur_cfg = random_cfg();
        cfg_i   <= cur_cfg;
        repeat (reset_cycles) @(posedge clk);
        rst_i <= 1'b0;

        // Single word against zero history
        repeat (5) idle_cycle();
        send_word(random_word(128));
        drain();

        repeat (words_per_phase) send_word(random_word(128));
        drain();

        load_cfg(random_cfg());
        for (int n = 0; n < words_per_phase; n++) begin
            send_word(random_word(128));
            gap = $urandom_range(max_gap, 0);
            repeat (gap) idle_cycle();
        end
        drain();

        // Codes near the threshold give wrong slicer decisions
        flag_ones  = 0;
        flag_zeros = 0;
        load_cfg(flag_cfg());
        repeat (words_per_phase) send_word(random_word(80));
        drain();

        if (flag_ones > 0 && flag_zeros > 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            fail_run("flags_o never showed both 0 and 1");
        end
    end

endmodule

`default_nettype wire

// File: ffe/ffe_slicer.sv
`timescale 1ns/1ns
`default_nettype none

module ffe_slicer (
    input  wire                            clk,
    input  wire                            rst_i,
    input  wire                            valid_i,
    input  wire dsp_types_pkg::code_word_t codes_i,
    input  wire dsp_cfg_pkg::dsp_cfg_t     cfg_i,
    output logic                           valid_o,
    output dsp_types_pkg::est_bit_word_t   est_bits_o,
    output dsp_types_pkg::bit_word_t       bits_o
);

    localparam int hist_len = dsp_cfg_pkg::ffe_taps - 1;
    localparam int ext_len  = dsp_types_pkg::lanes + hist_len;
    // Product of two codes plus growth for the tap sum
    localparam int acc_w    = 2 * dsp_types_pkg::code_w + 2;

    typedef logic signed [acc_w-1:0] acc_t;

    dsp_types_pkg::code_t [hist_len-1:0] hist_q;
    dsp_types_pkg::code_t [ext_len-1:0]  ext;
    dsp_types_pkg::est_bit_word_t        est_d;
    dsp_types_pkg::est_bit_word_t        est_q;
    logic                                valid_q;

    // Previous word's tail sits below the current word
    assign ext = {codes_i.lane, hist_q};

    always_comb begin
        acc_t                 acc;
        dsp_cfg_pkg::weight_t w;
        dsp_types_pkg::code_t c;
        for (int i = 0; i < dsp_types_pkg::lanes; i++) begin
            acc = '0;
            for (int j = 0; j < dsp_cfg_pkg::ffe_taps; j++) begin
                w   = cfg_i.weights[j];
                c   = ext[hist_len + i - j];
                acc = acc + acc_t'(w) * acc_t'(c);
            end
            acc = acc >>> cfg_i.ffe_shift;
            est_d.lane[i] = dsp_types_pkg::est_bit_t'(acc);
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_q <= 1'b0;
            hist_q  <= '0;
        end else begin
            valid_q <= valid_i;
            if (valid_i) begin
                hist_q <= codes_i.lane[dsp_types_pkg::lanes-1:dsp_types_pkg::lanes-hist_len];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (valid_i) begin
            est_q <= est_d;
        end
    end

    // Slicer
    always_comb begin
        for (int i = 0; i < dsp_types_pkg::lanes; i++) begin
            bits_o[i] = (est_q.lane[i] >= cfg_i.thresh);
        end
    end

    assign valid_o    = valid_q;
    assign est_bits_o = est_q;

endmodule

`default_nettype wire

// File: rtl/datapath_core.sv
`timescale 1ns/1ns
`default_nettype none

module datapath_core #(
    parameter int out_stages = 0
) (
    input  wire                                clk,
    input  wire                                rst_i,
    input  wire dsp_cfg_pkg::dsp_cfg_t         cfg_i,
    input  wire                                valid_i,
    input  wire dsp_types_pkg::code_word_t     codes_i,
    output logic                               valid_o,
    output dsp_types_pkg::est_bit_word_t       est_bits_o,
    output dsp_types_pkg::bit_word_t           bits_o,
    output dsp_types_pkg::est_code_word_t      est_codes_o,
    output dsp_types_pkg::err_word_t           errors_o,
    output dsp_types_pkg::flag_word_t          flags_o
);

    typedef struct packed {
        dsp_types_pkg::est_bit_word_t  est_bits;
        dsp_types_pkg::bit_word_t      bits;
        dsp_types_pkg::est_code_word_t est_codes;
        dsp_types_pkg::err_word_t      errors;
        dsp_types_pkg::flag_word_t     flags;
    } out_word_t;

    logic                          ffe_valid;
    dsp_types_pkg::est_bit_word_t  ffe_est_bits;
    dsp_types_pkg::bit_word_t      ffe_bits;
    logic                          chan_valid;
    dsp_types_pkg::est_code_word_t chan_est_codes;
    dsp_types_pkg::code_word_t     det_codes;
    logic                          det_bits_valid;
    dsp_types_pkg::bit_word_t      det_bits;
    logic                          det_valid;
    dsp_types_pkg::err_word_t      det_errors;
    dsp_types_pkg::flag_word_t     det_flags;
    out_word_t                     out_d;
    out_word_t                     out_q;

    ffe_slicer ffe0 (
        .clk       (clk),
        .rst_i     (rst_i),
        .valid_i   (valid_i),
        .codes_i   (codes_i),
        .cfg_i     (cfg_i),
        .valid_o   (ffe_valid),
        .est_bits_o(ffe_est_bits),
        .bits_o    (ffe_bits)
    );

    channel_filter chan0 (
        .clk        (clk),
        .rst_i      (rst_i),
        .valid_i    (ffe_valid),
        .bits_i     (ffe_bits),
        .cfg_i      (cfg_i),
        .valid_o    (chan_valid),
        .est_codes_o(chan_est_codes)
    );

    // Codes meet the channel output two cycles in
    lane_delay #(.width($bits(dsp_types_pkg::code_word_t)), .stages(2)) code_dly0 (
        .clk(clk), .rst_i(rst_i), .valid_i(valid_i), .data_i(codes_i),
        .valid_o(), .data_o(det_codes)
    );

    lane_delay #(.width($bits(dsp_types_pkg::bit_word_t)), .stages(1)) bits_dly0 (
        .clk(clk), .rst_i(rst_i), .valid_i(ffe_valid), .data_i(ffe_bits),
        .valid_o(det_bits_valid), .data_o(det_bits)
    );

    error_detector det0 (
        .clk        (clk),
        .rst_i      (rst_i),
        .valid_i    (chan_valid),
        .est_codes_i(chan_est_codes),
        .codes_i    (det_codes),
        .bits_i     (det_bits),
        .cfg_i      (cfg_i),
        .valid_o    (det_valid),
        .errors_o   (det_errors),
        .flags_o    (det_flags)
    );

    // Align early results with the detector output
    lane_delay #(.width($bits(dsp_types_pkg::est_bit_word_t)), .stages(3)) est_bits_dly0 (
        .clk(clk), .rst_i(rst_i), .valid_i(ffe_valid), .data_i(ffe_est_bits),
        .valid_o(), .data_o(out_d.est_bits)
    );

    lane_delay #(.width($bits(dsp_types_pkg::bit_word_t)), .stages(2)) bits_dly1 (
        .clk(clk), .rst_i(rst_i), .valid_i(det_bits_valid), .data_i(det_bits),
        .valid_o(), .data_o(out_d.bits)
    );

    lane_delay #(.width($bits(dsp_types_pkg::est_code_word_t)), .stages(2)) est_codes_dly0 (
        .clk(clk), .rst_i(rst_i), .valid_i(chan_valid), .data_i(chan_est_codes),
        .valid_o(), .data_o(out_d.est_codes)
    );

    assign out_d.errors = det_errors;
    assign out_d.flags  = det_flags;

    lane_delay #(.width($bits(out_word_t)), .stages(out_stages)) out_dly0 (
        .clk(clk), .rst_i(rst_i), .valid_i(det_valid), .data_i(out_d),
        .valid_o(valid_o), .data_o(out_q)
    );

    assign est_bits_o  = out_q.est_bits;
    assign bits_o      = out_q.bits;
    assign est_codes_o = out_q.est_codes;
    assign errors_o    = out_q.errors;
    assign flags_o     = out_q.flags;

endmodule

`default_nettype wire

// File: rtl/lane_delay.sv
`timescale 1ns/1ns
`default_nettype none

module lane_delay #(
    parameter int width  = 8,
    parameter int stages = 1
) (
    input  wire              clk,
    input  wire              rst_i,
    input  wire              valid_i,
    input  wire [width-1:0]  data_i,
    output logic             valid_o,
    output logic [width-1:0] data_o
);

    if (stages == 0) begin : g_pass
        assign valid_o = valid_i;
        assign data_o  = data_i;
    end else begin : g_pipe
        logic [stages-1:0]            valid_q;
        logic [stages-1:0][width-1:0] data_q;

        always_ff @(posedge clk) begin
            if (rst_i) begin
                valid_q <= '0;
            end else begin
                valid_q[0] <= valid_i;
                for (int i = 1; i < stages; i++) begin
                    valid_q[i] <= valid_q[i-1];
                end
            end
        end

        always_ff @(posedge clk) begin
            data_q[0] <= data_i;
            for (int i = 1; i < stages; i++) begin
                data_q[i] <= data_q[i-1];
            end
        end

        assign valid_o = valid_q[stages-1];
        assign data_o  = data_q[stages-1];
    end

endmodule

`default_nettype wire

// File: vlog.f
common/dsp_types_pkg.sv
common/dsp_cfg_pkg.sv
rtl/lane_delay.sv
ffe/ffe_slicer.sv
channel/channel_filter.sv
detector/error_detector.sv
rtl/datapath_core.sv
dv/datapath_core_assertions.sv
dv/datapath_core_tb.sv
